// ==== design/mesh_pkg.sv ====
// mesh_pkg
// Shared sizes, packet layout, opcodes and router port codes for the
// tiled compute array.

package mesh_pkg;

  // grid geometry
  localparam int NUM_X = 3;
  localparam int NUM_Y = 2;
  localparam int X_W = 2;
  localparam int Y_W = 1;

  // per-tile data memory
  localparam int DMEM_WORDS = 4;
  localparam int ADDR_W = 2;
  localparam int DATA_W = 16;

  typedef enum logic [1:0] {
    OP_STORE  = 2'd0,
    OP_LOAD   = 2'd1,
    OP_ARRIVE = 2'd2,
    OP_RESP   = 2'd3
  } mesh_op_e;

  localparam int OP_W = 2;
  localparam int PKT_W = OP_W + X_W + Y_W + ADDR_W + DATA_W;

  // packet is {op, dest_x, dest_y, addr, data} from the msb down
  localparam int DATA_LSB = 0;
  localparam int ADDR_LSB = DATA_LSB + DATA_W;
  localparam int DY_LSB = ADDR_LSB + ADDR_W;
  localparam int DX_LSB = DY_LSB + Y_W;
  localparam int OP_LSB = DX_LSB + X_W;

  // lower port code wins a clash for one output
  localparam int NUM_DIRS = 5;
  localparam int DIR_BITS = 3;
  localparam logic [DIR_BITS-1:0] DIR_LOC = 3'd0;
  localparam logic [DIR_BITS-1:0] DIR_WEST = 3'd1;
  localparam logic [DIR_BITS-1:0] DIR_NORTH = 3'd2;
  localparam logic [DIR_BITS-1:0] DIR_EAST = 3'd3;
  localparam logic [DIR_BITS-1:0] DIR_SOUTH = 3'd4;

endpackage

// ==== design/mesh_router.sv ====
// mesh_router
// Dimension-order router: requests go east then south, responses west then
// north. Link outputs are registered, the local eject port is not.

`timescale 1ns/1ps

module mesh_router
  import mesh_pkg::*;
#(
  parameter int TILE_X = 0,
  parameter int TILE_Y = 0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             north_v_i,
  input  logic [PKT_W-1:0] north_pkt_i,
  input  logic             south_v_i,
  input  logic [PKT_W-1:0] south_pkt_i,
  input  logic             east_v_i,
  input  logic [PKT_W-1:0] east_pkt_i,
  input  logic             west_v_i,
  input  logic [PKT_W-1:0] west_pkt_i,
  output logic             north_v_o,
  output logic [PKT_W-1:0] north_pkt_o,
  output logic             south_v_o,
  output logic [PKT_W-1:0] south_pkt_o,
  output logic             east_v_o,
  output logic [PKT_W-1:0] east_pkt_o,
  output logic             west_v_o,
  output logic [PKT_W-1:0] west_pkt_o,
  output logic             loc_v_o,
  output logic [PKT_W-1:0] loc_pkt_o,
  input  logic             loc_v_i,
  input  logic [PKT_W-1:0] loc_pkt_i
);

  logic [NUM_DIRS-1:0] in_v;
  logic [PKT_W-1:0]    in_pkt [NUM_DIRS];
  logic [NUM_DIRS-1:0] sel_v;
  logic [PKT_W-1:0]    sel_pkt [NUM_DIRS];
  // only the four link outputs have a register
  logic [NUM_DIRS-1:1] out_v_q;
  logic [PKT_W-1:0]    out_pkt_q [1:NUM_DIRS-1];

  function automatic logic [DIR_BITS-1:0] route_dir(input logic [PKT_W-1:0] pkt);
    mesh_op_e op;
    op = mesh_op_e'(pkt[OP_LSB +: OP_W]);
    if (op == OP_RESP) begin
      // back toward tile (0,0) and out its west side
      if (TILE_X > 0) return DIR_WEST;
      if (TILE_Y > 0) return DIR_NORTH;
      return DIR_WEST;
    end
    if (int'(pkt[DX_LSB +: X_W]) > TILE_X) return DIR_EAST;
    if (int'(pkt[DY_LSB +: Y_W]) > TILE_Y) return DIR_SOUTH;
    return DIR_LOC;
  endfunction

  // input index order doubles as priority
  assign in_v = {south_v_i, east_v_i, north_v_i, west_v_i, loc_v_i};
  assign in_pkt[DIR_LOC] = loc_pkt_i;
  assign in_pkt[DIR_WEST] = west_pkt_i;
  assign in_pkt[DIR_NORTH] = north_pkt_i;
  assign in_pkt[DIR_EAST] = east_pkt_i;
  assign in_pkt[DIR_SOUTH] = south_pkt_i;

  always_comb begin
    for (int o = 0; o < NUM_DIRS; o++) begin
      sel_v[o] = 1'b0;
      sel_pkt[o] = '0;
      // scan from lowest priority so the winner is written last
      for (int i = NUM_DIRS - 1; i >= 0; i--) begin
        if (in_v[i] && (route_dir(in_pkt[i]) == DIR_BITS'(o))) begin
          sel_v[o] = 1'b1;
          sel_pkt[o] = in_pkt[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_q <= '0;
    end else begin
      out_v_q <= sel_v[NUM_DIRS-1:1];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int d = 1; d < NUM_DIRS; d++) begin
      out_pkt_q[d] <= sel_pkt[d];
    end
  end

  // eject straight through, one hop per link register
  assign loc_v_o = sel_v[DIR_LOC];
  assign loc_pkt_o = sel_pkt[DIR_LOC];
  assign west_v_o = out_v_q[DIR_WEST];
  assign west_pkt_o = out_pkt_q[DIR_WEST];
  assign north_v_o = out_v_q[DIR_NORTH];
  assign north_pkt_o = out_pkt_q[DIR_NORTH];
  assign east_v_o = out_v_q[DIR_EAST];
  assign east_pkt_o = out_pkt_q[DIR_EAST];
  assign south_v_o = out_v_q[DIR_SOUTH];
  assign south_pkt_o = out_pkt_q[DIR_SOUTH];

endmodule

// ==== design/compute_tile.sv ====
// compute_tile
// One array tile: router, small data memory serving stores and loads,
// and a barrier flag feeding the barrier AND chain.

`timescale 1ns/1ps

module compute_tile
  import mesh_pkg::*;
#(
  parameter int TILE_X = 0,
  parameter int TILE_Y = 0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             north_v_i,
  input  logic [PKT_W-1:0] north_pkt_i,
  input  logic             south_v_i,
  input  logic [PKT_W-1:0] south_pkt_i,
  input  logic             east_v_i,
  input  logic [PKT_W-1:0] east_pkt_i,
  input  logic             west_v_i,
  input  logic [PKT_W-1:0] west_pkt_i,
  output logic             north_v_o,
  output logic [PKT_W-1:0] north_pkt_o,
  output logic             south_v_o,
  output logic [PKT_W-1:0] south_pkt_o,
  output logic             east_v_o,
  output logic [PKT_W-1:0] east_pkt_o,
  output logic             west_v_o,
  output logic [PKT_W-1:0] west_pkt_o,
  input  logic             bar_w_i,
  input  logic             bar_n_i,
  input  logic             bar_clear_i,
  output logic             bar_and_o
);

  logic              ej_v;
  logic [PKT_W-1:0]  ej_pkt;
  mesh_op_e          ej_op;
  logic [ADDR_W-1:0] ej_addr;
  logic              rsp_v;
  logic [PKT_W-1:0]  rsp_pkt;
  logic [DATA_W-1:0] dmem_q [DMEM_WORDS];
  logic              flag_q;

  mesh_router #(
    .TILE_X(TILE_X),
    .TILE_Y(TILE_Y)
  ) router (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .north_v_i  (north_v_i),
    .north_pkt_i(north_pkt_i),
    .south_v_i  (south_v_i),
    .south_pkt_i(south_pkt_i),
    .east_v_i   (east_v_i),
    .east_pkt_i (east_pkt_i),
    .west_v_i   (west_v_i),
    .west_pkt_i (west_pkt_i),
    .north_v_o  (north_v_o),
    .north_pkt_o(north_pkt_o),
    .south_v_o  (south_v_o),
    .south_pkt_o(south_pkt_o),
    .east_v_o   (east_v_o),
    .east_pkt_o (east_pkt_o),
    .west_v_o   (west_v_o),
    .west_pkt_o (west_pkt_o),
    .loc_v_o    (ej_v),
    .loc_pkt_o  (ej_pkt),
    .loc_v_i    (rsp_v),
    .loc_pkt_i  (rsp_pkt)
  );

  assign ej_op = mesh_op_e'(ej_pkt[OP_LSB +: OP_W]);
  assign ej_addr = ej_pkt[ADDR_LSB +: ADDR_W];

  // local data memory, written by ejected stores
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem_q[i] <= '0;
      end
    end else if (ej_v && (ej_op == OP_STORE)) begin
      dmem_q[ej_addr] <= ej_pkt[DATA_LSB +: DATA_W];
    end
  end

  // load reply is registered by the router on its way out
  assign rsp_v = ej_v && (ej_op == OP_LOAD);
  assign rsp_pkt = {OP_RESP, X_W'(TILE_X), Y_W'(TILE_Y), ej_addr, dmem_q[ej_addr]};

  // clear has priority over an arrive in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flag_q <= 1'b0;
    end else if (bar_clear_i) begin
      flag_q <= 1'b0;
    end else if (ej_v && (ej_op == OP_ARRIVE)) begin
      flag_q <= 1'b1;
    end
  end

  // last column also folds in the rows above
  assign bar_and_o = flag_q & bar_w_i & ((TILE_X == NUM_X - 1) ? bar_n_i : 1'b1);

endmodule

// ==== design/tile_array_mesh.sv ====
// tile_array_mesh
// Top of the tiled array: builds the tile grid, stitches packet and
// barrier links, and registers the barrier done pulse.

`timescale 1ns/1ps

module tile_array_mesh
  import mesh_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_v_i,
  input  logic [PKT_W-1:0] req_pkt_i,
  output logic             rsp_v_o,
  output logic [PKT_W-1:0] rsp_pkt_o,
  output logic             barrier_done_o
);

  // per-tile link ends indexed [y][x]
  logic [NUM_Y-1:0][NUM_X-1:0]            north_v_li, south_v_li, east_v_li, west_v_li;
  logic [NUM_Y-1:0][NUM_X-1:0][PKT_W-1:0] north_pkt_li, south_pkt_li;
  logic [NUM_Y-1:0][NUM_X-1:0][PKT_W-1:0] east_pkt_li, west_pkt_li;
  logic [NUM_Y-1:0][NUM_X-1:0]            north_v_lo, south_v_lo, east_v_lo, west_v_lo;
  logic [NUM_Y-1:0][NUM_X-1:0][PKT_W-1:0] north_pkt_lo, south_pkt_lo;
  logic [NUM_Y-1:0][NUM_X-1:0][PKT_W-1:0] east_pkt_lo, west_pkt_lo;
  logic [NUM_Y-1:0][NUM_X-1:0]            bar_w_li, bar_n_li, bar_and_lo;
  logic                                   done_q;

  for (genvar y = 0; y < NUM_Y; y++) begin : gen_y
    for (genvar x = 0; x < NUM_X; x++) begin : gen_x
      compute_tile #(
        .TILE_X(x),
        .TILE_Y(y)
      ) tile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .north_v_i  (north_v_li[y][x]),
        .north_pkt_i(north_pkt_li[y][x]),
        .south_v_i  (south_v_li[y][x]),
        .south_pkt_i(south_pkt_li[y][x]),
        .east_v_i   (east_v_li[y][x]),
        .east_pkt_i (east_pkt_li[y][x]),
        .west_v_i   (west_v_li[y][x]),
        .west_pkt_i (west_pkt_li[y][x]),
        .north_v_o  (north_v_lo[y][x]),
        .north_pkt_o(north_pkt_lo[y][x]),
        .south_v_o  (south_v_lo[y][x]),
        .south_pkt_o(south_pkt_lo[y][x]),
        .east_v_o   (east_v_lo[y][x]),
        .east_pkt_o (east_pkt_lo[y][x]),
        .west_v_o   (west_v_lo[y][x]),
        .west_pkt_o (west_pkt_lo[y][x]),
        .bar_w_i    (bar_w_li[y][x]),
        .bar_n_i    (bar_n_li[y][x]),
        .bar_clear_i(done_q),
        .bar_and_o  (bar_and_lo[y][x])
      );

      // request port enters the west side of (0,0)
      if (x == 0) begin : gen_w_edge
        assign west_v_li[y][x] = (y == 0) ? req_v_i : 1'b0;
        assign west_pkt_li[y][x] = (y == 0) ? req_pkt_i : '0;
        assign bar_w_li[y][x] = 1'b1;
      end else begin : gen_w_link
        assign west_v_li[y][x] = east_v_lo[y][x-1];
        assign west_pkt_li[y][x] = east_pkt_lo[y][x-1];
        assign bar_w_li[y][x] = bar_and_lo[y][x-1];
      end

      // east side carries responses back west
      if (x == NUM_X - 1) begin : gen_e_edge
        assign east_v_li[y][x] = 1'b0;
        assign east_pkt_li[y][x] = '0;
      end else begin : gen_e_link
        assign east_v_li[y][x] = west_v_lo[y][x+1];
        assign east_pkt_li[y][x] = west_pkt_lo[y][x+1];
      end

      if (y == 0) begin : gen_n_edge
        assign north_v_li[y][x] = 1'b0;
        assign north_pkt_li[y][x] = '0;
        assign bar_n_li[y][x] = 1'b1;
      end else begin : gen_n_link
        assign north_v_li[y][x] = south_v_lo[y-1][x];
        assign north_pkt_li[y][x] = south_pkt_lo[y-1][x];
        assign bar_n_li[y][x] = bar_and_lo[y-1][NUM_X-1];
      end

      if (y == NUM_Y - 1) begin : gen_s_edge
        assign south_v_li[y][x] = 1'b0;
        assign south_pkt_li[y][x] = '0;
      end else begin : gen_s_link
        assign south_v_li[y][x] = north_v_lo[y+1][x];
        assign south_pkt_li[y][x] = north_pkt_lo[y+1][x];
      end
    end
  end

  assign rsp_v_o = west_v_lo[0][0];
  assign rsp_pkt_o = west_pkt_lo[0][0];

  // flags clear on the same edge that ends the pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= bar_and_lo[NUM_Y-1][NUM_X-1] & ~done_q;
    end
  end

  assign barrier_done_o = done_q;

endmodule

// ==== dv/tile_array_mesh_assertions.sv ====
// tile_array_mesh_assertions
// Protocol checks on the array top: quiet edge links, response opcode,
// single-cycle barrier pulse and idle outputs in reset.

`timescale 1ns/1ps

module tile_array_mesh_assertions
  import mesh_pkg::*;
(
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          rsp_v_o,
  input logic [PKT_W-1:0]              rsp_pkt_o,
  input logic                          barrier_done_o,
  input logic [NUM_Y-1:0][NUM_X-1:0]   north_v_lo,
  input logic [NUM_Y-1:0][NUM_X-1:0]   east_v_lo,
  input logic [NUM_Y-1:0][NUM_X-1:0]   south_v_lo,
  input logic [NUM_Y-1:0][NUM_X-1:0]   west_v_lo,
  input logic [NUM_Y-1:0][NUM_X-1:0]   bar_and_lo
);

  int unsigned fail_cnt;
  logic        edge_v;

  initial fail_cnt = 0;

  // edge outputs other than the response port lead nowhere
  always_comb begin
    edge_v = 1'b0;
    for (int y = 0; y < NUM_Y; y++) begin
      edge_v |= east_v_lo[y][NUM_X-1];
    end
    for (int x = 0; x < NUM_X; x++) begin
      edge_v |= south_v_lo[NUM_Y-1][x];
      edge_v |= north_v_lo[0][x];
    end
    for (int y = 1; y < NUM_Y; y++) begin
      edge_v |= west_v_lo[y][0];
    end
  end

  edge_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i) !edge_v)
    else begin
      $error("valid packet on an unused edge link");
      fail_cnt++;
    end

  rsp_is_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_v_o |-> (rsp_pkt_o[OP_LSB +: OP_W] == OP_RESP))
    else begin
      $error("response port carried a non-response opcode");
      fail_cnt++;
    end

  // the pulse ends and the whole barrier chain has dropped
  done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    barrier_done_o |=> (!barrier_done_o && !bar_and_lo[NUM_Y-1][NUM_X-1]))
    else begin
      $error("barrier done longer than one cycle or flags not cleared");
      fail_cnt++;
    end

  reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |-> (!rsp_v_o && !barrier_done_o && !edge_v))
    else begin
      $error("outputs active during reset");
      fail_cnt++;
    end

endmodule

bind tile_array_mesh tile_array_mesh_assertions mesh_checks (.*);

// ==== dv/tile_array_mesh_tb.sv ====
// tile_array_mesh testbench
// Stores, loads and barrier arrives through the request port, checked
// against a memory model and the hop-count latency of each response.

`timescale 1ns/1ps

module tile_array_mesh_tb
  import mesh_pkg::*;
();

  localparam int unsigned SEED = 32'h2c7d;
  localparam int TIMEOUT = 50;

  logic             clk_i;
  logic             rst_n_i;
  logic             req_v_i;
  logic [PKT_W-1:0] req_pkt_i;
  logic             rsp_v_o;
  logic [PKT_W-1:0] rsp_pkt_o;
  logic             barrier_done_o;

  // copy of every tile memory indexed [y][x][addr]
  logic [DATA_W-1:0] model_mem [NUM_Y][NUM_X][DMEM_WORDS];
  logic [PKT_W-1:0]  exp_pkt_q [$];
  int unsigned       exp_cyc_q [$];
  int unsigned       cyc;
  int unsigned       err_cnt;
  int unsigned       timeout_cnt;
  int unsigned       pulse_cnt;

  tile_array_mesh tile_array_mesh_inst (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [DATA_W-1:0] exp_load(input int x, input int y, input int addr);
    return model_mem[y][x][addr];
  endfunction

  // op, dest_x, dest_y, addr, data from the top bit down
  function automatic logic [PKT_W-1:0] make_pkt(input mesh_op_e op, input int x, input int y,
                                                input int addr, input logic [DATA_W-1:0] data);
    return {op, X_W'(x), Y_W'(y), ADDR_W'(addr), data};
  endfunction

  task automatic send_pkt(input mesh_op_e op, input int x, input int y, input int addr,
                          input logic [DATA_W-1:0] data);
    @(posedge clk_i);
    req_v_i <= 1'b1;
    req_pkt_i <= make_pkt(op, x, y, addr, data);
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    req_v_i <= 1'b0;
    req_pkt_i <= '0;
  endtask

  task automatic store_word(input int x, input int y, input int addr,
                            input logic [DATA_W-1:0] data);
    send_pkt(OP_STORE, x, y, addr, data);
    model_mem[y][x][addr] = data;
  endtask

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = tile_array_mesh_inst.mesh_checks.fail_cnt;
    $display("errors: %0d checks, %0d timeouts, %0d assertions",
             err_cnt, timeout_cnt, assert_fails);
    if (err_cnt == 0 && timeout_cnt == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic wait_rsp();
    int n;
    n = 0;
    while (exp_pkt_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_pkt_q.size() != 0) begin
      $display("timeout while waiting for a load response");
      timeout_cnt++;
      exp_pkt_q.delete();
      exp_cyc_q.delete();
    end
  endtask

  task automatic wait_pulse(input int unsigned target);
    int n;
    n = 0;
    while (pulse_cnt < target && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (pulse_cnt < target) begin
      $display("timeout while waiting for the barrier done pulse");
      timeout_cnt++;
    end
  endtask

  task automatic load_check(input int x, input int y, input int addr);
    send_pkt(OP_LOAD, x, y, addr, '0);
    exp_pkt_q.push_back(make_pkt(OP_RESP, x, y, addr, exp_load(x, y, addr)));
    // cyc still holds the count from before this edge
    exp_cyc_q.push_back(cyc + 2 * (x + y) + 2);
    go_idle();
    wait_rsp();
  endtask

  task automatic check_pulses(input int unsigned expected);
    assert (pulse_cnt == expected) else begin
      $display("FAIL %0t: %0d done pulses, expected %0d", $time, pulse_cnt, expected);
      err_cnt++;
    end
  endtask

  // compare responses and count done pulses mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i && barrier_done_o) pulse_cnt++;
    if (rst_n_i && rsp_v_o) begin
      assert (exp_pkt_q.size() != 0) else begin
        $display("FAIL %0t: response %h with no load outstanding", $time, rsp_pkt_o);
        err_cnt++;
      end
      if (exp_pkt_q.size() != 0) begin
        assert (rsp_pkt_o == exp_pkt_q[0]) else begin
          $display("FAIL %0t: response %h, expected %h", $time, rsp_pkt_o, exp_pkt_q[0]);
          err_cnt++;
        end
        assert (cyc == exp_cyc_q[0]) else begin
          $display("FAIL %0t: response in cycle %0d, expected %0d", $time, cyc, exp_cyc_q[0]);
          err_cnt++;
        end
        void'(exp_pkt_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
    end
  end

  initial begin
    int x;
    int y;
    int a;
    rst_n_i = 1'b0;
    req_v_i = 1'b0;
    req_pkt_i = '0;
    cyc = 0;
    err_cnt = 0;
    timeout_cnt = 0;
    pulse_cnt = 0;
    void'($urandom(SEED));
    foreach (model_mem[i, j, k])
      model_mem[i][j][k] = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // every word reads back zero after reset
    foreach (model_mem[i, j, k])
      load_check(j, i, k);

    // random stores on consecutive cycles and then random loads
    for (int n = 0; n < 20; n++) begin
      x = $urandom_range(NUM_X - 1, 0);
      y = $urandom_range(NUM_Y - 1, 0);
      a = $urandom_range(DMEM_WORDS - 1, 0);
      store_word(x, y, a, DATA_W'($urandom));
    end
    go_idle();
    for (int n = 0; n < 20; n++) begin
      x = $urandom_range(NUM_X - 1, 0);
      y = $urandom_range(NUM_Y - 1, 0);
      a = $urandom_range(DMEM_WORDS - 1, 0);
      load_check(x, y, a);
    end

    // one store per tile back to back and a full read back
    for (int i = 0; i < NUM_Y; i++) begin
      for (int j = 0; j < NUM_X; j++) begin
        store_word(j, i, i + j, DATA_W'($urandom));
      end
    end
    go_idle();
    foreach (model_mem[i, j, k])
      load_check(j, i, k);

    // barrier with the last tile missing stays low
    for (int i = 0; i < NUM_X * NUM_Y - 1; i++)
      send_pkt(OP_ARRIVE, i % NUM_X, i / NUM_X, 0, '0);
    go_idle();
    repeat (10) @(posedge clk_i);
    check_pulses(0);
    send_pkt(OP_ARRIVE, NUM_X - 1, NUM_Y - 1, 0, '0);
    go_idle();
    wait_pulse(1);
    repeat (6) @(posedge clk_i);
    check_pulses(1);

    // a second full round needs the flags cleared by the first pulse
    for (int i = NUM_X * NUM_Y - 1; i >= 0; i--)
      send_pkt(OP_ARRIVE, i % NUM_X, i / NUM_X, 0, '0);
    go_idle();
    wait_pulse(2);
    repeat (6) @(posedge clk_i);
    check_pulses(2);

    finish_run();
  end

endmodule

// ==== src.f ====
design/mesh_pkg.sv
design/mesh_router.sv
design/compute_tile.sv
design/tile_array_mesh.sv
dv/tile_array_mesh_assertions.sv
dv/tile_array_mesh_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module tile_array_mesh_tb -f src.f -o sim_tb \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q 'All tests passed!' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
